// ==== axil_bridge_pkg.sv ====
package axil_bridge_pkg;

  // Field widths of the message header
  localparam int type_width_gp = 2;
  localparam int size_width_gp = 2;
  localparam int tag_width_gp  = 8;
  localparam int addr_width_gp = 32;
  localparam int hdr_width_gp  = type_width_gp + size_width_gp + tag_width_gp + addr_width_gp;

  // Field positions inside mem_hdr_t
  localparam int hdr_type_lsb = 0;
  localparam int hdr_size_lsb = hdr_type_lsb + type_width_gp;
  localparam int hdr_tag_lsb  = hdr_size_lsb + size_width_gp;
  localparam int hdr_addr_lsb = hdr_tag_lsb + tag_width_gp;

  typedef logic [tag_width_gp-1:0]  mem_tag_t;
  typedef logic [addr_width_gp-1:0] mem_addr_t;
  typedef logic [hdr_width_gp-1:0]  mem_hdr_t;

  // Cached and uncached message types
  typedef enum logic [type_width_gp-1:0]
  {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_type_e;

  // Log2 of the byte count
  typedef enum logic [size_width_gp-1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } mem_size_e;

endpackage

// ==== axil_req_if.sv ====
`timescale 1ns/10ps

interface axil_req_if
  #(parameter int data_width_p = 64
  , parameter int addr_width_p = 32
  );

  localparam int mask_width_lp = data_width_p >> 3;

  logic                     valid;
  logic                     ready;
  logic                     write;
  logic [addr_width_p-1:0]  addr;
  logic [data_width_p-1:0]  wdata;
  logic [mask_width_lp-1:0] wstrb;

  // Decode side
  modport source (output valid, write, addr, wdata, wstrb, input ready);

  // Channel engine side
  modport sink (input valid, write, addr, wdata, wstrb, output ready);

endinterface

// ==== mem_fwd_decode.sv ====
`timescale 1ns/10ps

module mem_fwd_decode
  #(parameter int axil_data_width_p = 64
  , parameter int axil_addr_width_p = 32
  )
  (input                                   clk_i
  , input                                  arst_n_i

  , input  axil_bridge_pkg::mem_type_e     fwd_type_i
  , input  axil_bridge_pkg::mem_size_e     fwd_size_i
  , input  axil_bridge_pkg::mem_tag_t      fwd_tag_i
  , input  axil_bridge_pkg::mem_addr_t     fwd_addr_i
  , input  logic [axil_data_width_p-1:0]   fwd_data_i
  , input  logic                           fwd_v_i
  , output logic                           fwd_ready_and_o

  , output axil_bridge_pkg::mem_hdr_t      hdr_push_o
  , output logic                           hdr_push_v_o
  , input  logic                           hdr_full_i

  , axil_req_if.source                     req
  );

  localparam int mask_width_lp   = axil_data_width_p >> 3;
  localparam int offset_width_lp = $clog2(mask_width_lp);

  logic                           init_done_r;
  logic                           req_v_r;
  logic                           fwd_accept;
  logic                           is_write;
  logic [offset_width_lp-1:0]     mask_shift;
  logic [mask_width_lp-1:0]       size_mask;
  logic [mask_width_lp-1:0]       wstrb;

  // Request slot is free or draining, and the header queue has room
  assign fwd_ready_and_o = init_done_r & ~hdr_full_i & (~req_v_r | req.ready);
  assign fwd_accept      = fwd_v_i & fwd_ready_and_o;

  assign is_write   = fwd_type_i inside {axil_bridge_pkg::e_mem_wr, axil_bridge_pkg::e_mem_uc_wr};
  assign mask_shift = fwd_addr_i[offset_width_lp-1:0];

  always_comb
  begin
    case (fwd_size_i)
      axil_bridge_pkg::e_size_1: size_mask = (mask_width_lp)'(4'h1);
      axil_bridge_pkg::e_size_2: size_mask = (mask_width_lp)'(4'h3);
      axil_bridge_pkg::e_size_4: size_mask = (mask_width_lp)'(4'hf);
      default:                   size_mask = '1;
    endcase
    // Full-width accesses enable every byte lane
    if (int'(fwd_size_i) >= offset_width_lp)
      wstrb = '1;
    else
      wstrb = size_mask << mask_shift;
  end

  // Packed header goes to the pending queue on acceptance
  always_comb
  begin
    hdr_push_o = '0;
    hdr_push_o[axil_bridge_pkg::hdr_type_lsb +: axil_bridge_pkg::type_width_gp] = fwd_type_i;
    hdr_push_o[axil_bridge_pkg::hdr_size_lsb +: axil_bridge_pkg::size_width_gp] = fwd_size_i;
    hdr_push_o[axil_bridge_pkg::hdr_tag_lsb  +: axil_bridge_pkg::tag_width_gp]  = fwd_tag_i;
    hdr_push_o[axil_bridge_pkg::hdr_addr_lsb +: axil_bridge_pkg::addr_width_gp] = fwd_addr_i;
  end
  assign hdr_push_v_o = fwd_accept;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      init_done_r <= 1'b0;
      req_v_r     <= 1'b0;
    end
    else
    begin
      init_done_r <= 1'b1;
      if (fwd_accept)
        req_v_r <= 1'b1;
      else if (req.ready)
        req_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_accept)
    begin
      req.write <= is_write;
      req.addr  <= fwd_addr_i[axil_addr_width_p-1:0];
      req.wdata <= fwd_data_i;
      req.wstrb <= wstrb;
    end
  end

  assign req.valid = req_v_r;

endmodule

// ==== pending_hdr_fifo.sv ====
`timescale 1ns/10ps

module pending_hdr_fifo
  (input                                clk_i
  , input                               arst_n_i

  , input  axil_bridge_pkg::mem_hdr_t   push_data_i
  , input  logic                        push_v_i
  , output logic                        full_o

  , output axil_bridge_pkg::mem_hdr_t   pop_data_o
  , input  logic                        pop_v_i
  );

  axil_bridge_pkg::mem_hdr_t mem_r [2];

  logic       wptr_r;
  logic       rptr_r;
  logic [1:0] count_r;

  assign full_o     = (count_r == 2'd2);
  // Oldest header is valid whenever the count is nonzero
  assign pop_data_o = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push_v_i)
      mem_r[wptr_r] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (push_v_i)
        wptr_r <= ~wptr_r;
      if (pop_v_i)
        rptr_r <= ~rptr_r;
      count_r <= count_r + 2'(push_v_i) - 2'(pop_v_i);
    end
  end

endmodule

// ==== axil_channel_engine.sv ====
`timescale 1ns/10ps

module axil_channel_engine
  #(parameter int axil_data_width_p = 64
  , parameter int axil_addr_width_p = 32
  , localparam int axil_mask_width_lp = axil_data_width_p >> 3
  )
  (input                                  clk_i
  , input                                 arst_n_i

  , axil_req_if.sink                      req

  , output logic [axil_addr_width_p-1:0]  m_axil_awaddr_o
  , output logic                          m_axil_awvalid_o
  , input  logic                          m_axil_awready_i

  , output logic [axil_data_width_p-1:0]  m_axil_wdata_o
  , output logic [axil_mask_width_lp-1:0] m_axil_wstrb_o
  , output logic                          m_axil_wvalid_o
  , input  logic                          m_axil_wready_i

  , input  logic                          m_axil_bvalid_i
  , output logic                          m_axil_bready_o

  , output logic [axil_addr_width_p-1:0]  m_axil_araddr_o
  , output logic                          m_axil_arvalid_o
  , input  logic                          m_axil_arready_i

  , input  logic [axil_data_width_p-1:0]  m_axil_rdata_i
  , input  logic                          m_axil_rvalid_i
  , output logic                          m_axil_rready_o

  , output logic                          rsp_v_o
  , input  logic                          rsp_ready_i
  , output logic [axil_data_width_p-1:0]  rsp_data_o
  );

  typedef enum logic [2:0]
  {
    e_idle,
    e_wr_addr_data,
    e_wr_resp,
    e_rd_addr,
    e_rd_data,
    e_rsp_hold
  } state_e;

  state_e state_r;

  logic                          aw_done_r;
  logic                          w_done_r;
  logic                          aw_fire;
  logic                          w_fire;
  logic [axil_addr_width_p-1:0]  addr_r;
  logic [axil_data_width_p-1:0]  wdata_r;
  logic [axil_mask_width_lp-1:0] wstrb_r;
  logic [axil_data_width_p-1:0]  rsp_data_r;

  // One transaction at a time
  assign req.ready = (state_r == e_idle);

  assign m_axil_awaddr_o  = addr_r;
  assign m_axil_araddr_o  = addr_r;
  assign m_axil_wdata_o   = wdata_r;
  assign m_axil_wstrb_o   = wstrb_r;

  // AW and W are tracked apart so each valid drops on its own handshake
  assign m_axil_awvalid_o = (state_r == e_wr_addr_data) & ~aw_done_r;
  assign m_axil_wvalid_o  = (state_r == e_wr_addr_data) & ~w_done_r;
  assign m_axil_bready_o  = (state_r == e_wr_resp);
  assign m_axil_arvalid_o = (state_r == e_rd_addr);
  assign m_axil_rready_o  = (state_r == e_rd_data);

  assign aw_fire = m_axil_awvalid_o & m_axil_awready_i;
  assign w_fire  = m_axil_wvalid_o & m_axil_wready_i;

  assign rsp_v_o    = (state_r == e_rsp_hold);
  assign rsp_data_o = rsp_data_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= e_idle;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end
    else
    begin
      case (state_r)
        e_idle:
          if (req.valid)
            state_r <= req.write ? e_wr_addr_data : e_rd_addr;
        e_wr_addr_data:
          if ((aw_done_r | aw_fire) & (w_done_r | w_fire))
          begin
            state_r   <= e_wr_resp;
            aw_done_r <= 1'b0;
            w_done_r  <= 1'b0;
          end
          else
          begin
            aw_done_r <= aw_done_r | aw_fire;
            w_done_r  <= w_done_r | w_fire;
          end
        e_wr_resp:
          if (m_axil_bvalid_i)
            state_r <= e_rsp_hold;
        e_rd_addr:
          if (m_axil_arready_i)
            state_r <= e_rd_data;
        e_rd_data:
          if (m_axil_rvalid_i)
            state_r <= e_rsp_hold;
        e_rsp_hold:
          if (rsp_ready_i)
            state_r <= e_idle;
        default:
          state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req.valid & req.ready)
    begin
      addr_r  <= req.addr;
      wdata_r <= req.wdata;
      wstrb_r <= req.wstrb;
    end
    // Write responses return zero data
    if (state_r == e_wr_resp && m_axil_bvalid_i)
      rsp_data_r <= '0;
    else if (state_r == e_rd_data && m_axil_rvalid_i)
      rsp_data_r <= m_axil_rdata_i;
  end

endmodule

// ==== mem_rev_pack.sv ====
`timescale 1ns/10ps

module mem_rev_pack
  #(parameter int axil_data_width_p = 64)
  (input                                   clk_i
  , input                                  arst_n_i

  , input  axil_bridge_pkg::mem_hdr_t      hdr_i
  , output logic                           hdr_pop_o

  , input  logic                           rsp_v_i
  , output logic                           rsp_ready_o
  , input  logic [axil_data_width_p-1:0]   rsp_data_i

  , output axil_bridge_pkg::mem_type_e     rev_type_o
  , output axil_bridge_pkg::mem_size_e     rev_size_o
  , output axil_bridge_pkg::mem_tag_t      rev_tag_o
  , output axil_bridge_pkg::mem_addr_t     rev_addr_o
  , output logic [axil_data_width_p-1:0]   rev_data_o
  , output logic                           rev_v_o
  , input  logic                           rev_ready_and_i
  );

  localparam int mask_width_lp   = axil_data_width_p >> 3;
  localparam int offset_width_lp = $clog2(mask_width_lp);

  axil_bridge_pkg::mem_size_e   hdr_size;
  logic [offset_width_lp-1:0]   byte_sel;
  logic [axil_data_width_p-1:0] shifted;
  logic [axil_data_width_p-1:0] packed_data;
  logic                         load;

  assign hdr_size = axil_bridge_pkg::mem_size_e'(
    hdr_i[axil_bridge_pkg::hdr_size_lsb +: axil_bridge_pkg::size_width_gp]);
  assign byte_sel = hdr_i[axil_bridge_pkg::hdr_addr_lsb +: offset_width_lp];

  // Bring the addressed bytes down to lane zero, then fill the word
  assign shifted = rsp_data_i >> {byte_sel, 3'b000};

  always_comb
  begin
    if (int'(hdr_size) >= offset_width_lp)
      packed_data = rsp_data_i;
    else
      case (hdr_size)
        axil_bridge_pkg::e_size_1: packed_data = {mask_width_lp{shifted[7:0]}};
        axil_bridge_pkg::e_size_2: packed_data = {(axil_data_width_p/16){shifted[15:0]}};
        default:                   packed_data = {(axil_data_width_p/32){shifted[31:0]}};
      endcase
  end

  // Output slot is empty or draining this cycle
  assign rsp_ready_o = ~rev_v_o | rev_ready_and_i;
  assign load        = rsp_v_i & rsp_ready_o;
  assign hdr_pop_o   = load;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rev_v_o <= 1'b0;
    else if (load)
      rev_v_o <= 1'b1;
    else if (rev_ready_and_i)
      rev_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      rev_type_o <= axil_bridge_pkg::mem_type_e'(
        hdr_i[axil_bridge_pkg::hdr_type_lsb +: axil_bridge_pkg::type_width_gp]);
      rev_size_o <= hdr_size;
      rev_tag_o  <= hdr_i[axil_bridge_pkg::hdr_tag_lsb +: axil_bridge_pkg::tag_width_gp];
      rev_addr_o <= hdr_i[axil_bridge_pkg::hdr_addr_lsb +: axil_bridge_pkg::addr_width_gp];
      rev_data_o <= packed_data;
    end
  end

endmodule

// ==== axil_bridge.sv ====
`timescale 1ns/10ps

module axil_bridge
  #(parameter int axil_data_width_p = 64
  , parameter int axil_addr_width_p = 32
  , localparam int axil_mask_width_lp = axil_data_width_p >> 3
  )
  (input                                  clk_i
  , input                                 arst_n_i

  // Forward messages
  , input  axil_bridge_pkg::mem_type_e    fwd_type_i
  , input  axil_bridge_pkg::mem_size_e    fwd_size_i
  , input  axil_bridge_pkg::mem_tag_t     fwd_tag_i
  , input  axil_bridge_pkg::mem_addr_t    fwd_addr_i
  , input  logic [axil_data_width_p-1:0]  fwd_data_i
  , input  logic                          fwd_v_i
  , output logic                          fwd_ready_and_o

  // Reverse messages
  , output axil_bridge_pkg::mem_type_e    rev_type_o
  , output axil_bridge_pkg::mem_size_e    rev_size_o
  , output axil_bridge_pkg::mem_tag_t     rev_tag_o
  , output axil_bridge_pkg::mem_addr_t    rev_addr_o
  , output logic [axil_data_width_p-1:0]  rev_data_o
  , output logic                          rev_v_o
  , input  logic                          rev_ready_and_i

  // AXI-lite master
  , output logic [axil_addr_width_p-1:0]  m_axil_awaddr_o
  , output logic                          m_axil_awvalid_o
  , input  logic                          m_axil_awready_i
  , output logic [axil_data_width_p-1:0]  m_axil_wdata_o
  , output logic [axil_mask_width_lp-1:0] m_axil_wstrb_o
  , output logic                          m_axil_wvalid_o
  , input  logic                          m_axil_wready_i
  , input  logic                          m_axil_bvalid_i
  , output logic                          m_axil_bready_o
  , output logic [axil_addr_width_p-1:0]  m_axil_araddr_o
  , output logic                          m_axil_arvalid_o
  , input  logic                          m_axil_arready_i
  , input  logic [axil_data_width_p-1:0]  m_axil_rdata_i
  , input  logic                          m_axil_rvalid_i
  , output logic                          m_axil_rready_o
  );

  axil_bridge_pkg::mem_hdr_t    hdr_push;
  axil_bridge_pkg::mem_hdr_t    hdr_pop_data;
  logic                         hdr_push_v;
  logic                         hdr_full;
  logic                         hdr_pop;
  logic                         rsp_v;
  logic                         rsp_ready;
  logic [axil_data_width_p-1:0] rsp_data;

  axil_req_if #(.data_width_p(axil_data_width_p), .addr_width_p(axil_addr_width_p)) req_if ();

  mem_fwd_decode
    #(.axil_data_width_p(axil_data_width_p)
    , .axil_addr_width_p(axil_addr_width_p)
    )
    decode_i
    (.clk_i, .arst_n_i
    , .fwd_type_i, .fwd_size_i, .fwd_tag_i, .fwd_addr_i, .fwd_data_i
    , .fwd_v_i, .fwd_ready_and_o
    , .hdr_push_o(hdr_push), .hdr_push_v_o(hdr_push_v), .hdr_full_i(hdr_full)
    , .req(req_if.source)
    );

  pending_hdr_fifo hdr_fifo_i
    (.clk_i, .arst_n_i
    , .push_data_i(hdr_push), .push_v_i(hdr_push_v), .full_o(hdr_full)
    , .pop_data_o(hdr_pop_data), .pop_v_i(hdr_pop)
    );

  axil_channel_engine
    #(.axil_data_width_p(axil_data_width_p)
    , .axil_addr_width_p(axil_addr_width_p)
    )
    engine_i
    (.clk_i, .arst_n_i
    , .req(req_if.sink)
    , .m_axil_awaddr_o, .m_axil_awvalid_o, .m_axil_awready_i
    , .m_axil_wdata_o, .m_axil_wstrb_o, .m_axil_wvalid_o, .m_axil_wready_i
    , .m_axil_bvalid_i, .m_axil_bready_o
    , .m_axil_araddr_o, .m_axil_arvalid_o, .m_axil_arready_i
    , .m_axil_rdata_i, .m_axil_rvalid_i, .m_axil_rready_o
    , .rsp_v_o(rsp_v), .rsp_ready_i(rsp_ready), .rsp_data_o(rsp_data)
    );

  mem_rev_pack #(.axil_data_width_p(axil_data_width_p)) pack_i
    (.clk_i, .arst_n_i
    , .hdr_i(hdr_pop_data), .hdr_pop_o(hdr_pop)
    , .rsp_v_i(rsp_v), .rsp_ready_o(rsp_ready), .rsp_data_i(rsp_data)
    , .rev_type_o, .rev_size_o, .rev_tag_o, .rev_addr_o, .rev_data_o
    , .rev_v_o, .rev_ready_and_i
    );

endmodule

// ==== tb_axil_mem.sv ====
`timescale 1ns/10ps

module tb_axil_mem
  #(parameter int data_width_p = 64
  , parameter int addr_width_p = 32
  , parameter logic [31:0] seed_p = 32'h9a655e48
  , localparam int mask_width_lp = data_width_p >> 3
  )
  (input                              clk_i

  , input  logic [addr_width_p-1:0]   awaddr_i
  , input  logic                      awvalid_i
  , output logic                      awready_o
  , input  logic [data_width_p-1:0]   wdata_i
  , input  logic [mask_width_lp-1:0]  wstrb_i
  , input  logic                      wvalid_i
  , output logic                      wready_o
  , output logic                      bvalid_o
  , input  logic                      bready_i

  , input  logic [addr_width_p-1:0]   araddr_i
  , input  logic                      arvalid_i
  , output logic                      arready_o
  , output logic [data_width_p-1:0]   rdata_o
  , output logic                      rvalid_o
  , input  logic                      rready_i
  );

  localparam int offset_lp = $clog2(mask_width_lp);

  logic [data_width_p-1:0] mem_r [256];
  integer                  seed = seed_p;

  // 0 to 3 cycles
  function automatic int rand_delay();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  initial
  begin : write_channel
    logic [addr_width_p-1:0]  wr_addr;
    logic [data_width_p-1:0]  wr_data;
    logic [mask_width_lp-1:0] wr_strb;
    mem_r     = '{default: '0};
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    forever
    begin
      next_cycle();
      if (awvalid_i)
      begin
        // AW and W are taken with independent delays
        fork
          begin
            repeat (rand_delay()) next_cycle();
            awready_o = 1'b1;
            wr_addr   = awaddr_i;
            next_cycle();
            awready_o = 1'b0;
          end
          begin
            repeat (rand_delay()) next_cycle();
            wready_o = 1'b1;
            wr_data  = wdata_i;
            wr_strb  = wstrb_i;
            next_cycle();
            wready_o = 1'b0;
          end
        join
        for (int b = 0; b < mask_width_lp; b++)
        begin
          if (wr_strb[b])
            mem_r[wr_addr[offset_lp +: 8]][8*b +: 8] = wr_data[8*b +: 8];
        end
        repeat (rand_delay()) next_cycle();
        bvalid_o = 1'b1;
        while (!bready_i)
          next_cycle();
        next_cycle();
        bvalid_o = 1'b0;
      end
    end
  end

  initial
  begin : read_channel
    logic [addr_width_p-1:0] rd_addr;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    forever
    begin
      next_cycle();
      if (arvalid_i)
      begin
        repeat (rand_delay()) next_cycle();
        arready_o = 1'b1;
        rd_addr   = araddr_i;
        next_cycle();
        arready_o = 1'b0;
        repeat (rand_delay()) next_cycle();
        rdata_o  = mem_r[rd_addr[offset_lp +: 8]];
        rvalid_o = 1'b1;
        while (!rready_i)
          next_cycle();
        next_cycle();
        rvalid_o = 1'b0;
      end
    end
  end

endmodule

// ==== axil_bridge_assert.sv ====
`timescale 1ns/10ps

module axil_bridge_assert
  (input  logic clk_i
  , input logic arst_n_i
  , input logic awvalid_i
  , input logic awready_i
  , input logic wvalid_i
  , input logic wready_i
  , input logic arvalid_i
  , input logic arready_i
  , input logic rev_v_i
  , input logic rev_ready_i
  , input logic fwd_ready_i
  );

  // Valids stay up until their handshake
  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before awready");

  w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before wready");

  ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else $error("arvalid dropped before arready");

  rev_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_v_i && !rev_ready_i |=> rev_v_i)
    else $error("rev_v_o dropped before rev_ready_and_i");

  fwd_ready_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !fwd_ready_i)
    else $error("fwd_ready_and_o high during reset");

endmodule

bind axil_bridge axil_bridge_assert assert_i
  (.clk_i, .arst_n_i
  , .awvalid_i(m_axil_awvalid_o), .awready_i(m_axil_awready_i)
  , .wvalid_i(m_axil_wvalid_o), .wready_i(m_axil_wready_i)
  , .arvalid_i(m_axil_arvalid_o), .arready_i(m_axil_arready_i)
  , .rev_v_i(rev_v_o), .rev_ready_i(rev_ready_and_i)
  , .fwd_ready_i(fwd_ready_and_o)
  );

// ==== tb_axil_bridge.sv ====
`timescale 1ns/10ps

module tb_axil_bridge;

  localparam int data_width_lp     = 64;
  localparam int addr_width_lp     = 32;
  localparam int mask_width_lp     = data_width_lp >> 3;
  localparam int stall_cycles_lp   = 40;
  localparam int cycles_per_msg_lp = 40;
  localparam logic [31:0] seed_init_lp = 32'h9a655e48;

  logic                        clk;
  logic                        arst_n;
  axil_bridge_pkg::mem_type_e  fwd_type;
  axil_bridge_pkg::mem_size_e  fwd_size;
  axil_bridge_pkg::mem_tag_t   fwd_tag;
  axil_bridge_pkg::mem_addr_t  fwd_addr;
  logic [data_width_lp-1:0]    fwd_data;
  logic                        fwd_v;
  logic                        fwd_ready_and;
  axil_bridge_pkg::mem_type_e  rev_type;
  axil_bridge_pkg::mem_size_e  rev_size;
  axil_bridge_pkg::mem_tag_t   rev_tag;
  axil_bridge_pkg::mem_addr_t  rev_addr;
  logic [data_width_lp-1:0]    rev_data;
  logic                        rev_v;
  logic                        rev_ready_and;

  logic [addr_width_lp-1:0] axil_awaddr;
  logic                     axil_awvalid;
  logic                     axil_awready;
  logic [data_width_lp-1:0] axil_wdata;
  logic [mask_width_lp-1:0] axil_wstrb;
  logic                     axil_wvalid;
  logic                     axil_wready;
  logic                     axil_bvalid;
  logic                     axil_bready;
  logic [addr_width_lp-1:0] axil_araddr;
  logic                     axil_arvalid;
  logic                     axil_arready;
  logic [data_width_lp-1:0] axil_rdata;
  logic                     axil_rvalid;
  logic                     axil_rready;

  // Trace columns
  logic [1:0]               type_q  [$];
  logic [1:0]               size_q  [$];
  logic [7:0]               tag_q   [$];
  logic [31:0]              addr_q  [$];
  logic [data_width_lp-1:0] wdata_q [$];
  logic [data_width_lp-1:0] exp_q   [$];

  integer seed = seed_init_lp;
  int     num_msgs;
  int     rcv_count;
  bit     trace_loaded;

  axil_bridge #(.axil_data_width_p(data_width_lp), .axil_addr_width_p(addr_width_lp)) dut_i
    (.clk_i(clk), .arst_n_i(arst_n)
    , .fwd_type_i(fwd_type), .fwd_size_i(fwd_size), .fwd_tag_i(fwd_tag)
    , .fwd_addr_i(fwd_addr), .fwd_data_i(fwd_data)
    , .fwd_v_i(fwd_v), .fwd_ready_and_o(fwd_ready_and)
    , .rev_type_o(rev_type), .rev_size_o(rev_size), .rev_tag_o(rev_tag)
    , .rev_addr_o(rev_addr), .rev_data_o(rev_data)
    , .rev_v_o(rev_v), .rev_ready_and_i(rev_ready_and)
    , .m_axil_awaddr_o(axil_awaddr), .m_axil_awvalid_o(axil_awvalid)
    , .m_axil_awready_i(axil_awready)
    , .m_axil_wdata_o(axil_wdata), .m_axil_wstrb_o(axil_wstrb)
    , .m_axil_wvalid_o(axil_wvalid), .m_axil_wready_i(axil_wready)
    , .m_axil_bvalid_i(axil_bvalid), .m_axil_bready_o(axil_bready)
    , .m_axil_araddr_o(axil_araddr), .m_axil_arvalid_o(axil_arvalid)
    , .m_axil_arready_i(axil_arready)
    , .m_axil_rdata_i(axil_rdata), .m_axil_rvalid_i(axil_rvalid)
    , .m_axil_rready_o(axil_rready)
    );

  tb_axil_mem #(.data_width_p(data_width_lp), .addr_width_p(addr_width_lp)
    , .seed_p(seed_init_lp)) mem_i
    (.clk_i(clk)
    , .awaddr_i(axil_awaddr), .awvalid_i(axil_awvalid), .awready_o(axil_awready)
    , .wdata_i(axil_wdata), .wstrb_i(axil_wstrb), .wvalid_i(axil_wvalid)
    , .wready_o(axil_wready), .bvalid_o(axil_bvalid), .bready_i(axil_bready)
    , .araddr_i(axil_araddr), .arvalid_i(axil_arvalid), .arready_o(axil_arready)
    , .rdata_o(axil_rdata), .rvalid_o(axil_rvalid), .rready_i(axil_rready)
    );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // One message per handshake and back to back where the DUT allows
  task automatic drive_messages();
    bit accepted;
    for (int i = 0; i < num_msgs; i++)
    begin
      fwd_type = axil_bridge_pkg::mem_type_e'(type_q[i]);
      fwd_size = axil_bridge_pkg::mem_size_e'(size_q[i]);
      fwd_tag  = tag_q[i];
      fwd_addr = addr_q[i];
      fwd_data = wdata_q[i];
      fwd_v    = 1'b1;
      accepted = 1'b0;
      while (!accepted)
      begin
        accepted = fwd_ready_and;
        next_cycle();
      end
    end
    fwd_v = 1'b0;
  endtask

  task automatic check_messages();
    int cycle;
    cycle = 0;
    while (rcv_count < num_msgs)
    begin
      // Initial stall fills the pipeline from the back
      if (cycle < stall_cycles_lp)
        rev_ready_and = 1'b0;
      else
        rev_ready_and = (($random(seed) % 4) != 0);
      if (cycle == stall_cycles_lp - 1)
      begin
        check_value("fwd_ready_and_o under stall", 64'(fwd_ready_and), 64'd0);
        check_value("rev_v_o under stall", 64'(rev_v), 64'd1);
      end
      if (rev_v && rev_ready_and)
      begin
        check_value($sformatf("rev_type_o (message %0d)", rcv_count),
                    64'(rev_type), 64'(type_q[rcv_count]));
        check_value($sformatf("rev_size_o (message %0d)", rcv_count),
                    64'(rev_size), 64'(size_q[rcv_count]));
        check_value($sformatf("rev_tag_o (message %0d)", rcv_count),
                    64'(rev_tag), 64'(tag_q[rcv_count]));
        check_value($sformatf("rev_addr_o (message %0d)", rcv_count),
                    64'(rev_addr), 64'(addr_q[rcv_count]));
        check_value($sformatf("rev_data_o (message %0d)", rcv_count),
                    rev_data, exp_q[rcv_count]);
        rcv_count++;
      end
      next_cycle();
      cycle++;
    end
    rev_ready_and = 1'b1;
  endtask

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    wait (trace_loaded);
    while (cycles < cycles_per_msg_lp * num_msgs)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Test FAILED");
    $fatal(1, "Timeout after %0d cycles, %0d of %0d reverse messages seen",
           cycles, rcv_count, num_msgs);
  end

  initial
  begin
    int                       fd;
    int                       fields;
    int                       extra_count;
    string                    line;
    logic [63:0]              col_type;
    logic [63:0]              col_size;
    logic [63:0]              col_tag;
    logic [63:0]              col_addr;
    logic [data_width_lp-1:0] col_wdata;
    logic [data_width_lp-1:0] col_exp;
    arst_n        = 1'b0;
    fwd_type      = axil_bridge_pkg::e_mem_rd;
    fwd_size      = axil_bridge_pkg::e_size_1;
    fwd_tag       = '0;
    fwd_addr      = '0;
    fwd_data      = '0;
    fwd_v         = 1'b0;
    rev_ready_and = 1'b0;
    rcv_count     = 0;

    fd = $fopen("axil_bridge_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Test FAILED");
      $fatal(1, "Cannot open axil_bridge_trace.txt");
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 0 && line[0] != "#")
      begin
        fields = $sscanf(line, "%h %h %h %h %h %h",
                         col_type, col_size, col_tag, col_addr, col_wdata, col_exp);
        if (fields == 6)
        begin
          type_q.push_back(col_type[1:0]);
          size_q.push_back(col_size[1:0]);
          tag_q.push_back(col_tag[7:0]);
          addr_q.push_back(col_addr[31:0]);
          wdata_q.push_back(col_wdata);
          exp_q.push_back(col_exp);
        end
      end
    end
    $fclose(fd);
    num_msgs = type_q.size();
    if (num_msgs == 0)
    begin
      $display("Test FAILED");
      $fatal(1, "Trace file holds no messages");
    end
    trace_loaded = 1'b1;

    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    fork
      drive_messages();
      check_messages();
    join

    // Nothing may follow the last expected message
    extra_count = 0;
    repeat (10)
    begin
      next_cycle();
      if (rev_v)
        extra_count++;
    end
    if (extra_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("Test FAILED");
      $fatal(1, "Reverse valid seen on %0d cycles after the last message", extra_count);
    end
  end

endmodule

// ==== axil_bridge_trace.txt ====
# type size tag addr wdata rev_data, all hex, one forward message per line
# type 0 rd, 1 wr, 2 uc_rd, 3 uc_wr; size is log2 of the byte count
1 3 01 00000040 0011223344556677 0000000000000000
1 0 02 00000041 aaaaaaaaaaaaaaaa 0000000000000000
3 1 03 00000046 bbbbbbbbbbbbbbbb 0000000000000000
0 3 04 00000040 0000000000000000 bbbb22334455aa77
3 3 05 00000080 8877665544332211 0000000000000000
1 2 06 00000084 cafef00dcafef00d 0000000000000000
1 1 07 00000082 1234123412341234 0000000000000000
3 0 08 00000087 5a5a5a5a5a5a5a5a 0000000000000000
2 3 09 00000080 0000000000000000 5afef00d12342211
0 0 0a 00000085 0000000000000000 f0f0f0f0f0f0f0f0
2 1 0b 00000086 0000000000000000 5afe5afe5afe5afe
0 2 0c 00000084 0000000000000000 5afef00d5afef00d
0 1 0d 00000082 0000000000000000 1234123412341234
0 0 0e 00000041 0000000000000000 aaaaaaaaaaaaaaaa
2 2 0f 00000040 0000000000000000 4455aa774455aa77
3 3 10 000000c8 0f1e2d3c4b5a6978 0000000000000000
1 0 11 000000cb eeeeeeeeeeeeeeee 0000000000000000
3 1 12 000000cc 9999999999999999 0000000000000000
0 3 13 000000c8 0000000000000000 0f1e9999ee5a6978
2 0 14 000000cf 0000000000000000 0f0f0f0f0f0f0f0f
0 1 15 000000ca 0000000000000000 ee5aee5aee5aee5a
0 3 16 00000040 0000000000000000 bbbb22334455aa77

// ==== axil_bridge.f ====
axil_bridge_pkg.sv
axil_req_if.sv
mem_fwd_decode.sv
pending_hdr_fifo.sv
axil_channel_engine.sv
mem_rev_pack.sv
axil_bridge.sv
tb_axil_mem.sv
axil_bridge_assert.sv
tb_axil_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axil_bridge
FILELIST  ?= axil_bridge.f
OBJ_DIR   ?= obj_dir
TRACE     ?= axil_bridge_trace.txt
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
